//--- logic/issue_pkg.sv
// ------------------------------------------------------------
// shared widths, unit and operation encodings, and the packed
// structs passed between scoreboard, issue stage and execute
// import with issue_pkg::* in the module header
// ------------------------------------------------------------
package issue_pkg;

    // integer datapath width
    localparam int unsigned XLEN = 32;
    // architectural register index width
    localparam int unsigned REG_ADDR_BITS = 5;
    localparam int unsigned NR_REGS = 32;
    // scoreboard entry tag
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [XLEN-1:0] xlen_t;

    // functional unit that executes an instruction
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        LOAD,
        STORE,
        MULT,
        CSR
    } fu_t;

    // operation inside the selected unit
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        SRL,
        BEQ,
        BNE,
        JALR,
        LW,
        SW,
        MUL,
        CSRRW,
        SFENCE_VMA
    } fu_op_t;

    // one scoreboard entry offered for issue
    typedef struct packed {
        xlen_t                    pc;
        logic [TRANS_ID_BITS-1:0] trans_id;
        fu_t                      fu;
        fu_op_t                   op;
        reg_addr_t                rs1;
        reg_addr_t                rs2;
        reg_addr_t                rd;
        // immediate lives here until writeback
        xlen_t                    result;
        logic                     use_imm;
        logic                     use_zimm;
        logic                     use_pc;
        logic                     ex_valid;
        logic                     is_compressed;
    } issue_instr_t;

    // per register, the unit that will write it, NONE if none
    typedef fu_t [NR_REGS-1:0] clobber_t;

    // one commit stage write port
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

    // payload toward the execute units
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   op;
        xlen_t                    operand_a;
        xlen_t                    operand_b;
        xlen_t                    imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // issue strobes, at most one high per cycle
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

endpackage

//--- logic/int_regfile.sv
// ------------------------------------------------------------
// integer register file, two combinational read ports and
// NR_COMMIT_PORTS write ports driven by the commit stage
// x0 is not stored and always reads zero
// ------------------------------------------------------------
`timescale 1ns/100ps

module int_regfile import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  reg_addr_t                          raddr_a_i,
    input  reg_addr_t                          raddr_b_i,
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    output xlen_t                              rdata_a_o,
    output xlen_t                              rdata_b_o
);

    // x1 .. x31 only
    xlen_t mem_q [1:NR_REGS-1];
    logic  x0_bad_write;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int unsigned r = 1; r < NR_REGS; r++) begin
                mem_q[r] <= '0;
            end
        end else begin
            // later ports overwrite earlier ones on an address clash
            for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
                if (commit_i[p].we && commit_i[p].waddr != '0) begin
                    mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // no bypass, a write shows up one cycle after its edge
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

    // commit must never try to put data into x0
    always_comb begin
        x0_bad_write = 1'b0;
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr == '0 && commit_i[p].wdata != '0) begin
                x0_bad_write = 1'b1;
            end
        end
    end

    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !x0_bad_write
    ) else $error("commit port wrote nonzero data to x0");

endmodule

//--- logic/hazard_check.sv
// ------------------------------------------------------------
// issue decision for the entry at the head of the scoreboard
// checks source availability, forwarding, unit readiness and
// WAW, and drives the combinational acknowledge and stall
// ------------------------------------------------------------
`timescale 1ns/100ps

module hazard_check import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_instr_t                       issue_instr_i,
    input  logic                               issue_instr_valid_i,
    input  clobber_t                           clobber_i,
    input  logic                               rs1_fwd_valid_i,
    input  logic                               rs2_fwd_valid_i,
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                               flu_ready_i,
    input  logic                               lsu_ready_i,
    input  logic                               stall_i,
    // registered mult strobe of the issue register
    input  logic                               mult_issued_i,
    output logic                               forward_rs1_o,
    output logic                               forward_rs2_o,
    output logic                               issue_ack_o,
    output logic                               stall_issue_o
);

    logic fu_busy;
    logic rd_free;
    fu_t  rs1_clobber;
    fu_t  rs2_clobber;

    assign rs1_clobber = clobber_i[issue_instr_i.rs1];
    assign rs2_clobber = clobber_i[issue_instr_i.rs2];

    // ------------------------------------------------------------
    // busy flag of the unit the instruction needs
    // ------------------------------------------------------------
    always_comb begin
        unique case (issue_instr_i.fu)
            ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
            LOAD, STORE:               fu_busy = ~lsu_ready_i;
            default:                   fu_busy = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // operand availability
    // ------------------------------------------------------------
    always_comb begin
        stall_issue_o = stall_i;
        forward_rs1_o = 1'b0;
        forward_rs2_o = 1'b0;
        // zimm is an immediate, nothing to wait for in rs1
        if (!issue_instr_i.use_zimm && rs1_clobber != NONE) begin
            // CSR results cannot be forwarded, except around sfence.vma
            if (rs1_fwd_valid_i && (rs1_clobber != CSR || issue_instr_i.op == SFENCE_VMA)) begin
                forward_rs1_o = 1'b1;
            end else begin
                stall_issue_o = 1'b1;
            end
        end
        if (rs2_clobber != NONE) begin
            if (rs2_fwd_valid_i && (rs2_clobber != CSR || issue_instr_i.op == SFENCE_VMA)) begin
                forward_rs2_o = 1'b1;
            end else begin
                stall_issue_o = 1'b1;
            end
        end
    end

    // WAW, rd is free or is being retired right now
    always_comb begin
        rd_free = (clobber_i[issue_instr_i.rd] == NONE);
        for (int unsigned p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && commit_i[p].waddr == issue_instr_i.rd) begin
                rd_free = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // acknowledge
    // ------------------------------------------------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_instr_valid_i) begin
            if (!stall_issue_o && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries need no operands or unit
            if (issue_instr_i.ex_valid || issue_instr_i.fu == NONE) begin
                issue_ack_o = 1'b1;
            end
        end
        // the mult result owns the fixed latency writeback next cycle
        if (mult_issued_i && issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR}) begin
            issue_ack_o = 1'b0;
        end
        a_ack_has_valid: assert (!issue_ack_o || issue_instr_valid_i)
            else $error("issue acknowledge without a valid entry");
    end

endmodule

//--- logic/operand_select.sv
// ------------------------------------------------------------
// operand multiplexers in front of the issue register
// picks zimm, PC, forwarded or register file value for a,
// and the immediate, forwarded or register file value for b
// ------------------------------------------------------------
`timescale 1ns/100ps

module operand_select import issue_pkg::*; (
    input  issue_instr_t issue_instr_i,
    input  xlen_t        rdata_a_i,
    input  xlen_t        rdata_b_i,
    input  xlen_t        rs1_fwd_i,
    input  xlen_t        rs2_fwd_i,
    input  logic         forward_rs1_i,
    input  logic         forward_rs2_i,
    output fu_data_t     fu_data_o
);

    logic imm_as_b;

    // stores keep the immediate as address offset, branches as target
    assign imm_as_b = issue_instr_i.use_imm
                      && issue_instr_i.fu != STORE
                      && issue_instr_i.fu != CTRL_FLOW;

    // ------------------------------------------------------------
    // operand a, first match wins
    // ------------------------------------------------------------
    always_comb begin
        if (issue_instr_i.use_zimm) begin
            // csr immediate variants carry zimm in the rs1 field
            fu_data_o.operand_a = {{(XLEN-REG_ADDR_BITS){1'b0}}, issue_instr_i.rs1};
        end else if (issue_instr_i.use_pc) begin
            fu_data_o.operand_a = issue_instr_i.pc;
        end else if (forward_rs1_i) begin
            fu_data_o.operand_a = rs1_fwd_i;
        end else begin
            fu_data_o.operand_a = rdata_a_i;
        end
    end

    // ------------------------------------------------------------
    // operand b
    // ------------------------------------------------------------
    always_comb begin
        if (imm_as_b) begin
            fu_data_o.operand_b = issue_instr_i.result;
        end else if (forward_rs2_i) begin
            fu_data_o.operand_b = rs2_fwd_i;
        end else begin
            fu_data_o.operand_b = rdata_b_i;
        end
    end

    // immediate is always passed on, stores and branches need it
    assign fu_data_o.imm      = issue_instr_i.result;
    assign fu_data_o.fu       = issue_instr_i.fu;
    assign fu_data_o.op       = issue_instr_i.op;
    assign fu_data_o.trans_id = issue_instr_i.trans_id;

endmodule

//--- logic/issue_regs.sv
// ------------------------------------------------------------
// issue to execute pipeline register
// payload loads every cycle, one unit strobe is raised the
// cycle after acceptance, flush drops any pending strobe
// ------------------------------------------------------------
`timescale 1ns/100ps

module issue_regs import issue_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    // instruction taken this cycle
    input  logic         accept_i,
    input  issue_instr_t issue_instr_i,
    input  fu_data_t     fu_data_i,
    output fu_data_t     fu_data_o,
    output xlen_t        pc_o,
    output logic         is_compressed_o,
    output unit_valid_t  valid_o,
    output logic         mult_issued_o
);

    unit_valid_t valid_d;

    // ------------------------------------------------------------
    // strobe decode
    // ------------------------------------------------------------
    always_comb begin
        valid_d = '0;
        // faulting entries pass through without starting a unit
        if (accept_i && !issue_instr_i.ex_valid) begin
            unique case (issue_instr_i.fu)
                ALU:         valid_d.alu    = 1'b1;
                CTRL_FLOW:   valid_d.branch = 1'b1;
                LOAD, STORE: valid_d.lsu    = 1'b1;
                MULT:        valid_d.mult   = 1'b1;
                CSR:         valid_d.csr    = 1'b1;
                default:     valid_d        = '0;
            endcase
        end
        // flush wins over a same cycle accept
        if (flush_i) begin
            valid_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= '0;
        end else begin
            valid_o <= valid_d;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fu_data_o       <= '{fu: NONE, op: ADD, default: '0};
            pc_o            <= '0;
            is_compressed_o <= 1'b0;
        end else begin
            // only meaningful while a strobe is high
            fu_data_o       <= fu_data_i;
            pc_o            <= issue_instr_i.pc;
            is_compressed_o <= issue_instr_i.is_compressed;
        end
    end

    // hazard_check blocks flu users behind a multiply
    assign mult_issued_o = valid_o.mult;

    a_strobe_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(valid_o)
    ) else $error("more than one unit strobe raised");

endmodule

//--- logic/issue_stage.sv
// ------------------------------------------------------------
// integer issue and operand read stage of the in-order core
// takes the scoreboard head, reads or forwards its operands
// and starts one execute unit per accepted instruction
// ------------------------------------------------------------
`timescale 1ns/100ps

module issue_stage import issue_pkg::*; #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  logic                               stall_i,
    // scoreboard head
    input  issue_instr_t                       issue_instr_i,
    input  logic                               issue_instr_valid_i,
    output logic                               issue_ack_o,
    input  clobber_t                           clobber_i,
    // forwarding lookup
    output reg_addr_t                          rs1_o,
    input  xlen_t                              rs1_fwd_i,
    input  logic                               rs1_fwd_valid_i,
    output reg_addr_t                          rs2_o,
    input  xlen_t                              rs2_fwd_i,
    input  logic                               rs2_fwd_valid_i,
    // commit stage writes
    input  commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // execute side
    input  logic                               flu_ready_i,
    input  logic                               lsu_ready_i,
    output fu_data_t                           fu_data_o,
    output xlen_t                              pc_o,
    output logic                               is_compressed_o,
    output unit_valid_t                        valid_o,
    output logic                               stall_issue_o
);

    xlen_t    rdata_a, rdata_b;
    logic     forward_rs1, forward_rs2;
    logic     mult_issued;
    fu_data_t fu_data_next;

    // scoreboard is polled with the source indices directly
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    int_regfile #(.NR_COMMIT_PORTS(NR_COMMIT_PORTS)) i_int_regfile (
        .clk_i, .rst_ni,
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .commit_i,
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    hazard_check #(.NR_COMMIT_PORTS(NR_COMMIT_PORTS)) i_hazard_check (
        .issue_instr_i, .issue_instr_valid_i, .clobber_i,
        .rs1_fwd_valid_i, .rs2_fwd_valid_i, .commit_i,
        .flu_ready_i, .lsu_ready_i, .stall_i,
        .mult_issued_i (mult_issued),
        .forward_rs1_o (forward_rs1),
        .forward_rs2_o (forward_rs2),
        .issue_ack_o, .stall_issue_o
    );

    operand_select i_operand_select (
        .issue_instr_i,
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .rs1_fwd_i, .rs2_fwd_i,
        .forward_rs1_i (forward_rs1),
        .forward_rs2_i (forward_rs2),
        .fu_data_o     (fu_data_next)
    );

    issue_regs i_issue_regs (
        .clk_i, .rst_ni, .flush_i,
        .accept_i      (issue_ack_o),
        .issue_instr_i,
        .fu_data_i     (fu_data_next),
        .fu_data_o, .pc_o, .is_compressed_o, .valid_o,
        .mult_issued_o (mult_issued)
    );

endmodule

//--- dv/issue_table.svh
// ------------------------------------------------------------
// stimulus and expected results for the issue stage testbench
// one add_row call per cycle, applied in order by the testbench
// ------------------------------------------------------------

// columns: instr(fu, op, rs1, rs2, rd, imm, {imm,zimm,pc,ex}),
// clobber addr/unit x2, fwd valid {rs2,rs1}, commit we {p1,p0},
// commit addr p0, p1, {flu,lsu,flush,stall}, {ack,stall_issue},
// operand a source, operand b source, strobes {alu,br,lsu,mult,csr}
task automatic build_table();
    // register file writes, read back one cycle later
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b11, 5'd1, 5'd2, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b10000);
    add_row(pack_instr(ALU, SUB, 5'd1, 5'd2, 5'd6, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b11, 5'd4, 5'd5, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b10000);
    // both ports hit x7, port 1 must win
    add_row(pack_instr(ALU, XOR_OP, 5'd4, 5'd5, 5'd8, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b11, 5'd7, 5'd7, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b10000);
    add_row(pack_instr(ALU, OR_OP, 5'd7, 5'd0, 5'd9, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b10000);
    // operand selection, pc, zimm and immediate
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0010),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_PC, SRC_RF2, 5'b10000);
    add_row(pack_instr(CSR, CSRRW, 5'd21, 5'd4, 5'd10, 32'h0, 4'b0100),
            5'd21, ALU, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_ZIMM, SRC_RF2, 5'b00001);
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd11, 32'h7ff, 4'b1000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_IMM, 5'b10000);
    add_row(pack_instr(STORE, SW, 5'd2, 5'd4, 5'd0, 32'h40, 4'b1000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b00100);
    add_row(pack_instr(CTRL_FLOW, BEQ, 5'd1, 5'd2, 5'd0, 32'h100, 4'b1000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b01000);
    // forwarding, missing forward, csr clobberer, sfence.vma
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd12, 32'h0, 4'b0000),
            5'd1, LOAD, 5'd2, MULT, 2'b11, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_FWD1, SRC_FWD2, 5'b10000);
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd12, 32'h0, 4'b0000),
            5'd1, LOAD, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b01, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(ALU, ADD, 5'd4, 5'd5, 5'd13, 32'h0, 4'b0000),
            5'd5, CSR, 5'd0, NONE, 2'b11, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b01, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(CSR, SFENCE_VMA, 5'd4, 5'd5, 5'd0, 32'h0, 4'b0000),
            5'd4, CSR, 5'd0, NONE, 2'b11, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_FWD1, SRC_RF2, 5'b00001);
    // waw on rd, then rd retired in the same cycle
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd9, 32'h0, 4'b0000),
            5'd9, ALU, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b00, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd9, 32'h0, 4'b0000),
            5'd9, ALU, 5'd0, NONE, 2'b00, 2'b10, 5'd0, 5'd9, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b10000);
    // unit readiness
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b0100, 2'b00, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(LOAD, LW, 5'd2, 5'd0, 5'd14, 32'h8, 4'b1000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1000, 2'b00, SRC_RF1, SRC_IMM, 5'b00000);
    add_row(pack_instr(LOAD, LW, 5'd2, 5'd0, 5'd14, 32'h8, 4'b1000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_IMM, 5'b00100);
    // multiply blocks the alu for one cycle
    add_row(pack_instr(MULT, MUL, 5'd4, 5'd5, 5'd15, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b00010);
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b00, SRC_RF1, SRC_RF2, 5'b00000);
    // exception and unit-less entries pass a stall
    add_row(pack_instr(ALU, ADD, 5'd1, 5'd2, 5'd3, 32'h0, 4'b0001),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1101, 2'b11, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(NONE, ADD, 5'd0, 5'd0, 5'd0, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b0101, 2'b11, SRC_RF1, SRC_RF2, 5'b00000);
    // flush drops the strobe of the accepted alu op
    add_row(pack_instr(ALU, ADD, 5'd4, 5'd5, 5'd3, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1110, 2'b10, SRC_RF1, SRC_RF2, 5'b00000);
    add_row(pack_instr(CSR, CSRRW, 5'd4, 5'd0, 5'd16, 32'h0, 4'b0000),
            5'd0, NONE, 5'd0, NONE, 2'b00, 2'b00, 5'd0, 5'd0, 4'b1100, 2'b10, SRC_RF1, SRC_RF2, 5'b00001);
endtask

//--- dv/tb_issue_stage.sv
// ------------------------------------------------------------
// testbench for the integer issue stage
// walks the table in issue_table.svh, one row per cycle, and
// checks acknowledge, stall, strobes and operands per row
// ------------------------------------------------------------
`timescale 1ns/100ps

module tb_issue_stage import issue_pkg::*;;

    localparam int CLK_PERIOD = 10;
    localparam int unsigned SEED = 32'hc9f14d6e;

    // where an expected operand comes from
    typedef enum logic [2:0] {
        SRC_RF1, SRC_RF2, SRC_FWD1, SRC_FWD2, SRC_PC, SRC_ZIMM, SRC_IMM
    } src_t;

    typedef struct packed {
        issue_instr_t instr;
        reg_addr_t    clob_addr0;
        fu_t          clob_fu0;
        reg_addr_t    clob_addr1;
        fu_t          clob_fu1;
        // bit 0 rs1, bit 1 rs2
        logic [1:0]   fwd_valid;
        logic [1:0]   commit_we;
        reg_addr_t    commit_addr0;
        reg_addr_t    commit_addr1;
        logic [3:0]   ctl;
        logic         exp_ack;
        logic         exp_stall;
        src_t         exp_a;
        src_t         exp_b;
        unit_valid_t  exp_valid;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    logic flush_i = 1'b0;
    logic stall_i = 1'b0;
    issue_instr_t issue_instr_i = '0;
    logic issue_instr_valid_i = 1'b0;
    clobber_t clobber_i = '0;
    xlen_t rs1_fwd_i = '0;
    xlen_t rs2_fwd_i = '0;
    logic rs1_fwd_valid_i = 1'b0;
    logic rs2_fwd_valid_i = 1'b0;
    commit_port_t [1:0] commit_i = '0;
    logic flu_ready_i = 1'b1;
    logic lsu_ready_i = 1'b1;
    logic issue_ack_o, is_compressed_o, stall_issue_o;
    reg_addr_t rs1_o, rs2_o;
    fu_data_t fu_data_o;
    xlen_t pc_o;
    unit_valid_t valid_o;

    row_t rows[$];
    // reference copy of the register file
    xlen_t shadow [NR_REGS];
    xlen_t cdata [2];
    int unsigned errors = 0;
    int unsigned checks = 0;
    int cur_row = 0;

    issue_stage #(.NR_COMMIT_PORTS(2)) i_dut (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // ------------------------------------------------------------
    // table helpers
    // ------------------------------------------------------------
    function automatic issue_instr_t pack_instr(fu_t fu, fu_op_t op, reg_addr_t rs1,
            reg_addr_t rs2, reg_addr_t rd, xlen_t imm, logic [3:0] flags);
        issue_instr_t ins;
        ins = '0;
        // pc and tag follow the row position
        ins.pc = 32'h8000_0000 + xlen_t'(4 * rows.size());
        ins.trans_id = 3'(rows.size());
        // odd rows carry compressed encodings
        ins.is_compressed = 1'(rows.size());
        ins.fu = fu;
        ins.op = op;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.rd = rd;
        ins.result = imm;
        {ins.use_imm, ins.use_zimm, ins.use_pc, ins.ex_valid} = flags;
        return ins;
    endfunction

    function automatic void add_row(issue_instr_t ins, reg_addr_t ca0, fu_t cf0, reg_addr_t ca1,
            fu_t cf1, logic [1:0] fwd_v, logic [1:0] cw, reg_addr_t wa0, reg_addr_t wa1,
            logic [3:0] ctl, logic [1:0] exp, src_t a_src, src_t b_src, unit_valid_t vld);
        rows.push_back('{instr: ins, clob_addr0: ca0, clob_fu0: cf0, clob_addr1: ca1,
            clob_fu1: cf1, fwd_valid: fwd_v, commit_we: cw, commit_addr0: wa0,
            commit_addr1: wa1, ctl: ctl, exp_ack: exp[1], exp_stall: exp[0],
            exp_a: a_src, exp_b: b_src, exp_valid: vld});
    endfunction

    `include "issue_table.svh"

    function automatic xlen_t expected_operand(src_t src, issue_instr_t ins);
        case (src)
            SRC_RF1:  return shadow[ins.rs1];
            SRC_RF2:  return shadow[ins.rs2];
            SRC_FWD1: return rs1_fwd_i;
            SRC_FWD2: return rs2_fwd_i;
            SRC_PC:   return ins.pc;
            SRC_ZIMM: return xlen_t'(ins.rs1);
            default:  return ins.result;
        endcase
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic compare_ack(input logic got, input logic exp, input string sig);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d %s is %0b, expected %0b",
                $time, cur_row, sig, got, exp);
        end
    endtask

    task automatic compare_addr(input reg_addr_t got, input reg_addr_t exp, input string sig);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d %s is %0d, expected %0d",
                $time, cur_row, sig, got, exp);
        end
    endtask

    task automatic compare_word(input xlen_t got, input xlen_t exp, input string sig);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d %s is %h, expected %h",
                $time, cur_row, sig, got, exp);
        end
    endtask

    task automatic compare_data(input fu_data_t got, input fu_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d fu_data_o fu %0d op %0d a %h b %h imm %h id %0d",
                $time, cur_row, got.fu, got.op, got.operand_a, got.operand_b, got.imm,
                got.trans_id);
            $display("    expected fu %0d op %0d a %h b %h imm %h id %0d", exp.fu, exp.op,
                exp.operand_a, exp.operand_b, exp.imm, exp.trans_id);
        end
    endtask

    task automatic compare_valid(input unit_valid_t got, input unit_valid_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: row %0d valid_o is %b, expected %b",
                $time, cur_row, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // drive one row onto the DUT inputs
    // ------------------------------------------------------------
    task automatic apply_row(input row_t r, input int idx);
        issue_instr_i = r.instr;
        issue_instr_valid_i = 1'b1;
        clobber_i = '0;
        clobber_i[r.clob_addr0] = r.clob_fu0;
        clobber_i[r.clob_addr1] = r.clob_fu1;
        rs1_fwd_i = 32'hf1f1_0000 + xlen_t'(idx);
        rs2_fwd_i = 32'hf2f2_0000 + xlen_t'(idx);
        rs1_fwd_valid_i = r.fwd_valid[0];
        rs2_fwd_valid_i = r.fwd_valid[1];
        cdata[0] = $urandom;
        cdata[1] = $urandom;
        commit_i[0] = '{waddr: r.commit_addr0, wdata: cdata[0], we: r.commit_we[0]};
        commit_i[1] = '{waddr: r.commit_addr1, wdata: cdata[1], we: r.commit_we[1]};
        {flu_ready_i, lsu_ready_i, flush_i, stall_i} = r.ctl;
    endtask

    // watchdog sized from the table once it is built
    initial begin : watchdog
        #1;
        #((10 + rows.size() * 3) * CLK_PERIOD);
        $display("watchdog expired before all rows were applied");
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        row_t r;
        fu_data_t exp_data;
        int unsigned row_errors;
        void'($urandom(SEED));
        build_table();
        for (int k = 0; k < NR_REGS; k++) begin
            shadow[k] = '0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            cur_row = i;
            row_errors = errors;
            apply_row(r, i);
            // operands as the stage must read them in this cycle
            exp_data.fu = r.instr.fu;
            exp_data.op = r.instr.op;
            exp_data.operand_a = expected_operand(r.exp_a, r.instr);
            exp_data.operand_b = expected_operand(r.exp_b, r.instr);
            exp_data.imm = r.instr.result;
            exp_data.trans_id = r.instr.trans_id;
            #(CLK_PERIOD/2 - 1);
            compare_ack(issue_ack_o, r.exp_ack, "issue_ack_o");
            compare_ack(stall_issue_o, r.exp_stall, "stall_issue_o");
            // forwarding lookup follows the source fields
            compare_addr(rs1_o, r.instr.rs1, "rs1_o");
            compare_addr(rs2_o, r.instr.rs2, "rs2_o");
            // port 1 is applied last so it wins on the same address
            if (r.commit_we[0] && r.commit_addr0 != '0) begin
                shadow[r.commit_addr0] = cdata[0];
            end
            if (r.commit_we[1] && r.commit_addr1 != '0) begin
                shadow[r.commit_addr1] = cdata[1];
            end
            @(negedge clk_i);
            compare_valid(valid_o, r.exp_valid);
            if (r.exp_valid != '0) begin
                compare_data(fu_data_o, exp_data);
                compare_word(pc_o, r.instr.pc, "pc_o");
                compare_ack(is_compressed_o, r.instr.is_compressed, "is_compressed_o");
            end
            $display("row %0d: %s", i, (errors == row_errors) ? "ok" : "mismatch");
        end
        issue_instr_valid_i = 1'b0;
        commit_i = '0;
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+dv
logic/issue_pkg.sv
logic/int_regfile.sv
logic/hazard_check.sv
logic/operand_select.sv
logic/issue_regs.sv
logic/issue_stage.sv
dv/tb_issue_stage.sv

//--- run.sh
#!/bin/sh
# compile the issue stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_stage -f list.f -o sim_issue_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_issue_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -qx "Regression passed"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0
